/* Makefile */
# Verilator lint and simulation of the pipelined processor

TOP = procTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sources.f

# The run passes only if the log holds the pass line
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* hdl/decode.sv */
// --------------------------------------------------
// Decode stage
//   field and immediate decoding
//   branch and jump resolution with redirect
//   sticky halt and illegal opcode error
//   ID/EX pipeline register
// --------------------------------------------------
module decode (
	input  logic clk,
	input  logic reset,
	input  procPkg::ifIdT ifId,
	input  logic stall,
	input  procPkg::word rsData,
	input  procPkg::word rtData,
	output procPkg::regAddr rsAddr,
	output procPkg::regAddr rtAddr,
	output logic [1:0] srcUsed,
	output logic redirect,
	output procPkg::word redirectPc,
	output logic haltSeen,
	output procPkg::idExT idEx,
	output logic err
);

	procPkg::idExT nextIdEx;
	procPkg::word imm5, imm8, imm11;
	logic [1:0] used;
	logic isHalt, illegal, taken;
	logic haltReg;

	assign rsAddr = ifId.instr[10:8];
	assign rtAddr = ifId.instr[7:5];
	assign imm5 = {{11{ifId.instr[4]}}, ifId.instr[4:0]};
	assign imm8 = {{8{ifId.instr[7]}}, ifId.instr[7:0]};
	assign imm11 = {{5{ifId.instr[10]}}, ifId.instr[10:0]};

	always_comb begin
		nextIdEx = '0;
		nextIdEx.valid = ifId.valid && !stall;
		nextIdEx.aluFunc = procPkg::ADD;
		nextIdEx.srcA = rsData;
		nextIdEx.srcB = rtData;
		used = 2'b00;
		isHalt = 1'b0;
		illegal = 1'b0;
		taken = 1'b0;
		redirectPc = ifId.pcNext + imm8;
		case (ifId.instr[15:11])
			procPkg::HALT: isHalt = 1'b1;
			procPkg::NOP: ;
			procPkg::J: begin
				taken = 1'b1;
				redirectPc = ifId.pcNext + imm11;
			end
			procPkg::ADDI, procPkg::LD: begin
				nextIdEx.regWrite = 1'b1;
				nextIdEx.dest = rtAddr;
				nextIdEx.useImm = 1'b1;
				nextIdEx.imm = imm5;
				nextIdEx.memRead = (ifId.instr[15:11] == procPkg::LD);
				used = 2'b01;
			end
			procPkg::ST: begin
				nextIdEx.memWrite = 1'b1;
				nextIdEx.useImm = 1'b1;
				nextIdEx.imm = imm5;
				used = 2'b11;
			end
			procPkg::LBI: begin
				// Zero base so the ALU add passes the immediate
				nextIdEx.regWrite = 1'b1;
				nextIdEx.dest = rsAddr;
				nextIdEx.useImm = 1'b1;
				nextIdEx.imm = imm8;
				nextIdEx.srcA = '0;
			end
			procPkg::BEQZ: begin
				taken = (rsData == '0);
				used = 2'b01;
			end
			procPkg::BNEZ: begin
				taken = (rsData != '0);
				used = 2'b01;
			end
			procPkg::ALU: begin
				nextIdEx.regWrite = 1'b1;
				nextIdEx.dest = ifId.instr[4:2];
				nextIdEx.aluFunc = procPkg::aluFuncT'(ifId.instr[1:0]);
				used = 2'b11;
			end
			default: begin
				illegal = 1'b1;
				isHalt = 1'b1;
			end
		endcase
		nextIdEx.halt = isHalt;
		srcUsed = ifId.valid ? used : 2'b00;
	end

	// Branch is unresolved while its source is in flight
	assign redirect = ifId.valid && taken && !stall;
	assign haltSeen = haltReg || (ifId.valid && isHalt);

	always_ff @(posedge clk) begin
		if (reset) begin
			haltReg <= 1'b0;
			err <= 1'b0;
			idEx.valid <= 1'b0;
		end else begin
			haltReg <= haltSeen;
			err <= err || (ifId.valid && illegal);
			idEx <= nextIdEx;
		end
	end

endmodule

/* hdl/execute.sv */
// --------------------------------------------------
// Execute stage
//   ALU with add, subtract, xor and and
//   address generation for loads and stores
//   EX/MEM pipeline register
// --------------------------------------------------
module execute (
	input  logic clk,
	input  logic reset,
	input  procPkg::idExT idEx,
	output procPkg::exMemT exMem
);

	procPkg::word opB;
	procPkg::word aluOut;

	assign opB = idEx.useImm ? idEx.imm : idEx.srcB;

	// LBI arrives with srcA cleared, so ADD passes imm
	always_comb begin
		case (idEx.aluFunc)
			procPkg::ADD: aluOut = idEx.srcA + opB;
			procPkg::SUB: aluOut = idEx.srcA - opB;
			procPkg::XOR: aluOut = idEx.srcA ^ opB;
			procPkg::AND: aluOut = idEx.srcA & opB;
			default: aluOut = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			exMem.valid <= 1'b0;
		end else begin
			exMem.valid <= idEx.valid;
			exMem.regWrite <= idEx.regWrite;
			exMem.dest <= idEx.dest;
			exMem.memRead <= idEx.memRead;
			exMem.memWrite <= idEx.memWrite;
			exMem.halt <= idEx.halt;
			exMem.result <= aluOut;
			// Store value is rt
			exMem.storeData <= idEx.srcB;
		end
	end

endmodule

/* hdl/fetch.sv */
// --------------------------------------------------
// Fetch stage
//   program counter with stall, redirect and halt
//   instruction memory loaded by strobe in reset
//   IF/ID pipeline register
// --------------------------------------------------
module fetch #(
	parameter int imemWords = 256
) (
	input  logic clk,
	input  logic reset,
	input  logic loadValid,
	input  procPkg::word loadAddr,
	input  procPkg::word loadData,
	input  logic stall,
	input  logic redirect,
	input  procPkg::word redirectPc,
	input  logic haltSeen,
	output procPkg::ifIdT ifId
);

	localparam int idxW = $clog2(imemWords);

	procPkg::word imem [imemWords];
	procPkg::word pc;
	procPkg::word pcPlus2;
	procPkg::word instr;

	assign pcPlus2 = pc + 16'd2;
	// Word index from byte address
	assign instr = imem[pc[idxW:1]];

	always_ff @(posedge clk) begin
		if (loadValid) begin
			imem[loadAddr[idxW:1]] <= loadData;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			ifId.valid <= 1'b0;
		end else if (stall) begin
			// Hold PC and the IF/ID slot
			pc <= pc;
		end else if (redirect) begin
			pc <= redirectPc;
			ifId.valid <= 1'b0;
		end else if (haltSeen) begin
			ifId.valid <= 1'b0;
		end else begin
			pc <= pcPlus2;
			ifId.valid <= 1'b1;
			ifId.instr <= instr;
			ifId.pcNext <= pcPlus2;
		end
	end

endmodule

/* hdl/hazardUnit.sv */
// --------------------------------------------------
// Hazard unit
//   compares decode sources with pending
//   destinations in execute and memory
//   drives the decode stall
// --------------------------------------------------
module hazardUnit (
	input  procPkg::regAddr rsAddr,
	input  procPkg::regAddr rtAddr,
	input  logic [1:0] srcUsed,
	input  procPkg::idExT idEx,
	input  procPkg::exMemT exMem,
	output logic stall
);

	logic exWrites, memWrites;
	logic rsHit, rtHit;

	assign exWrites = idEx.valid && idEx.regWrite;
	assign memWrites = exMem.valid && exMem.regWrite;

	// Writeback needs no check, regFile bypasses it
	assign rsHit = (exWrites && idEx.dest == rsAddr) ||
		(memWrites && exMem.dest == rsAddr);
	assign rtHit = (exWrites && idEx.dest == rtAddr) ||
		(memWrites && exMem.dest == rtAddr);

	// srcUsed[0] is rs, srcUsed[1] is rt
	assign stall = (srcUsed[0] && rsHit) || (srcUsed[1] && rtHit);

endmodule

/* hdl/memory.sv */
// --------------------------------------------------
// Memory stage
//   word-wide data memory, combinational read
//   sticky misaligned access error
//   MEM/WB register with sticky halt
// --------------------------------------------------
module memory #(
	parameter int dmemWords = 256
) (
	input  logic clk,
	input  logic reset,
	input  procPkg::exMemT exMem,
	output procPkg::memWbT wb,
	output logic err
);

	localparam int addrW = $clog2(dmemWords);

	procPkg::word dmem [dmemWords];
	procPkg::word loadData;
	logic [addrW-1:0] dmemIdx;
	logic access, misaligned;

	assign dmemIdx = exMem.result[addrW:1];
	assign access = exMem.valid && (exMem.memRead || exMem.memWrite);
	assign misaligned = access && exMem.result[0];
	assign loadData = dmem[dmemIdx];

	// Odd address suppresses the store
	always_ff @(posedge clk) begin
		if (access && exMem.memWrite && !misaligned) begin
			dmem[dmemIdx] <= exMem.storeData;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wb.valid <= 1'b0;
			wb.regWrite <= 1'b0;
			wb.halt <= 1'b0;
			err <= 1'b0;
		end else begin
			wb.valid <= exMem.valid;
			wb.regWrite <= exMem.valid && exMem.regWrite && !misaligned;
			wb.dest <= exMem.dest;
			wb.halt <= wb.halt || (exMem.valid && exMem.halt);
			wb.data <= exMem.memRead ? loadData : exMem.result;
			err <= err || misaligned;
		end
	end

endmodule

/* hdl/proc.sv */
// --------------------------------------------------
// Processor top level
//   five-stage pipeline, fetch to writeback
//   register file beside decode, hazard unit
//   retire, halted and error outputs
// --------------------------------------------------
module proc #(
	parameter int imemWords = 256,
	parameter int dmemWords = 256
) (
	input  logic clk,
	input  logic reset,
	input  logic loadValid,
	input  procPkg::word loadAddr,
	input  procPkg::word loadData,
	output logic retireValid,
	output procPkg::regAddr retireReg,
	output procPkg::word retireData,
	output logic halted,
	output logic err
);

	procPkg::ifIdT ifId;
	procPkg::idExT idEx;
	procPkg::exMemT exMem;
	procPkg::memWbT wb;

	procPkg::regAddr rsAddr, rtAddr;
	procPkg::word rsData, rtData;
	logic [1:0] srcUsed;

	logic redirect;
	procPkg::word redirectPc;
	logic haltSeen;
	logic stall;

	logic decErr, memErr;

	fetch #(
		.imemWords(imemWords)
	) uFetch (
		.clk(clk),
		.reset(reset),
		.loadValid(loadValid),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.stall(stall),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.haltSeen(haltSeen),
		.ifId(ifId)
	);

	decode uDecode (
		.clk(clk),
		.reset(reset),
		.ifId(ifId),
		.stall(stall),
		.rsData(rsData),
		.rtData(rtData),
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.srcUsed(srcUsed),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.haltSeen(haltSeen),
		.idEx(idEx),
		.err(decErr)
	);

	// Written from the writeback bus
	regFile uRegFile (
		.clk(clk),
		.reset(reset),
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.wb(wb),
		.rsData(rsData),
		.rtData(rtData)
	);

	hazardUnit uHazardUnit (
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.srcUsed(srcUsed),
		.idEx(idEx),
		.exMem(exMem),
		.stall(stall)
	);

	execute uExecute (
		.clk(clk),
		.reset(reset),
		.idEx(idEx),
		.exMem(exMem)
	);

	memory #(
		.dmemWords(dmemWords)
	) uMemory (
		.clk(clk),
		.reset(reset),
		.exMem(exMem),
		.wb(wb),
		.err(memErr)
	);

	assign retireValid = wb.valid && wb.regWrite;
	assign retireReg = wb.dest;
	assign retireData = wb.data;
	assign halted = wb.halt;
	assign err = decErr || memErr;

endmodule

/* hdl/procPkg.sv */
// --------------------------------------------------
// Shared processor definitions
//   word and register number types
//   opcode and ALU function encodings
//   pipeline register structs IF/ID to MEM/WB
// --------------------------------------------------
package procPkg;

	// Data, address and instruction width
	typedef logic [15:0] word;
	typedef logic [2:0] regAddr;

	// Opcode field, bits 15..11 of an instruction
	typedef enum logic [4:0] {
		HALT = 5'b00000,
		NOP  = 5'b00001,
		J    = 5'b00100,
		ADDI = 5'b01000,
		BEQZ = 5'b01100,
		BNEZ = 5'b01101,
		ST   = 5'b10000,
		LD   = 5'b10001,
		LBI  = 5'b11000,
		ALU  = 5'b11011
	} opcodeT;

	// SUB computes rs minus rt
	typedef enum logic [1:0] {
		ADD = 2'b00,
		SUB = 2'b01,
		XOR = 2'b10,
		AND = 2'b11
	} aluFuncT;

	typedef struct packed {
		logic valid;
		word instr;
		word pcNext;
	} ifIdT;

	typedef struct packed {
		logic valid;
		logic regWrite;
		regAddr dest;
		aluFuncT aluFunc;
		logic useImm;
		logic memRead;
		logic memWrite;
		logic halt;
		word srcA;
		word srcB;
		word imm;
	} idExT;

	typedef struct packed {
		logic valid;
		logic regWrite;
		regAddr dest;
		logic memRead;
		logic memWrite;
		logic halt;
		word result;
		word storeData;
	} exMemT;

	// halt stays set once a halting instruction has passed
	typedef struct packed {
		logic valid;
		logic regWrite;
		regAddr dest;
		logic halt;
		word data;
	} memWbT;

endpackage

/* hdl/regFile.sv */
// --------------------------------------------------
// Register file
//   eight 16-bit registers, two read ports
//   one write port from writeback with bypass
// --------------------------------------------------
module regFile (
	input  logic clk,
	input  logic reset,
	input  procPkg::regAddr rsAddr,
	input  procPkg::regAddr rtAddr,
	input  procPkg::memWbT wb,
	output procPkg::word rsData,
	output procPkg::word rtData
);

	procPkg::word regs [8];
	logic wbWrite;

	assign wbWrite = wb.valid && wb.regWrite;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (wbWrite) begin
			regs[wb.dest] <= wb.data;
		end
	end

	// Same-cycle writeback shows up on the read ports
	assign rsData = (wbWrite && wb.dest == rsAddr) ? wb.data : regs[rsAddr];
	assign rtData = (wbWrite && wb.dest == rtAddr) ? wb.data : regs[rtAddr];

endmodule

/* sources.f */
hdl/procPkg.sv
hdl/fetch.sv
hdl/decode.sv
hdl/regFile.sv
hdl/hazardUnit.sv
hdl/execute.sv
hdl/memory.sv
hdl/proc.sv
testbench/proc_props.sv
testbench/procTb.sv

/* testbench/procTb.sv */
// --------------------------------------------------
// Processor testbench
//   clock, reset and program loading per test
//   table of programs with expected register writes
//   retire checks, watchdog and summary
// --------------------------------------------------
module procTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int clkPeriod = 4;
	localparam int numTests = 6;
	localparam int maxCycles = 200;
	// Load, reset and drain on top of the run itself
	localparam int cyclesPerTest = maxCycles + 40;

	typedef struct packed {
		procPkg::regAddr dest;
		procPkg::word data;
	} retireT;

	logic clk;
	logic reset;
	logic loadValid;
	procPkg::word loadAddr;
	procPkg::word loadData;
	logic retireValid;
	procPkg::regAddr retireReg;
	procPkg::word retireData;
	logic halted;
	logic err;

	int errors;
	int checks;

	// Unused program words stay 0, which is HALT
	string testName [numTests];
	procPkg::word prog [numTests][16];
	int progLen [numTests];
	retireT expRet [numTests][16];
	int expCount [numTests];
	logic expErr [numTests];

	proc #(
		.imemWords(256),
		.dmemWords(256)
	) u_proc (
		.clk(clk),
		.reset(reset),
		.loadValid(loadValid),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.retireValid(retireValid),
		.retireReg(retireReg),
		.retireData(retireData),
		.halted(halted),
		.err(err)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial begin
		#(numTests * cyclesPerTest * clkPeriod);
		$display("Watchdog: run did not finish within %0d cycles", numTests * cyclesPerTest);
		$display("test failed");
		$finish;
	end

	function automatic procPkg::word sext5(logic [4:0] v);
		return {{11{v[4]}}, v};
	endfunction

	function automatic procPkg::word sext8(logic [7:0] v);
		return {{8{v[7]}}, v};
	endfunction

	// Instruction encoders, fields as in the ISA
	function automatic procPkg::word iType(procPkg::opcodeT op, procPkg::regAddr rs,
			procPkg::regAddr rt, logic [4:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic procPkg::word lbiInstr(procPkg::regAddr rs, logic [7:0] imm);
		return {procPkg::LBI, rs, imm};
	endfunction

	function automatic procPkg::word branchInstr(procPkg::opcodeT op, procPkg::regAddr rs,
			logic [7:0] imm);
		return {op, rs, imm};
	endfunction

	function automatic procPkg::word jumpInstr(logic [10:0] imm);
		return {procPkg::J, imm};
	endfunction

	function automatic procPkg::word aluInstr(procPkg::regAddr rs, procPkg::regAddr rt,
			procPkg::regAddr rd, procPkg::aluFuncT f);
		return {procPkg::ALU, rs, rt, rd, f};
	endfunction

	task automatic addInstr(input int t, input procPkg::word w);
		prog[t][progLen[t]] = w;
		progLen[t]++;
	endtask

	task automatic expectWrite(input int t, input procPkg::regAddr r, input procPkg::word d);
		expRet[t][expCount[t]] = '{dest: r, data: d};
		expCount[t]++;
	endtask

	task automatic buildTable();
		logic [7:0] a;
		logic [7:0] b;
		logic [4:0] c;
		procPkg::word r1;
		procPkg::word r2;
		procPkg::word r3;
		a = 8'($urandom);
		b = 8'($urandom);
		c = 5'($urandom);
		for (int t = 0; t < numTests; t++) begin
			progLen[t] = 0;
			expCount[t] = 0;
			for (int i = 0; i < 16; i++) begin
				prog[t][i] = '0;
			end
		end

		testName[0] = "aluRandom";
		r1 = sext8(a);
		r2 = sext8(b);
		r3 = r1 + sext5(c);
		addInstr(0, lbiInstr(3'd1, a));
		addInstr(0, lbiInstr(3'd2, b));
		addInstr(0, iType(procPkg::ADDI, 3'd1, 3'd3, c));
		addInstr(0, aluInstr(3'd1, 3'd2, 3'd4, procPkg::ADD));
		addInstr(0, aluInstr(3'd1, 3'd2, 3'd5, procPkg::SUB));
		addInstr(0, aluInstr(3'd3, 3'd1, 3'd6, procPkg::XOR));
		addInstr(0, aluInstr(3'd3, 3'd2, 3'd7, procPkg::AND));
		expectWrite(0, 3'd1, r1);
		expectWrite(0, 3'd2, r2);
		expectWrite(0, 3'd3, r3);
		expectWrite(0, 3'd4, r1 + r2);
		expectWrite(0, 3'd5, r1 - r2);
		expectWrite(0, 3'd6, r3 ^ r1);
		expectWrite(0, 3'd7, r3 & r2);
		expErr[0] = 1'b0;

		// Every instruction reads the one before it
		testName[1] = "depChain";
		addInstr(1, lbiInstr(3'd1, 8'd5));
		addInstr(1, iType(procPkg::ADDI, 3'd1, 3'd1, 5'd3));
		addInstr(1, iType(procPkg::ADDI, 3'd1, 3'd2, 5'h1f));
		addInstr(1, aluInstr(3'd2, 3'd1, 3'd3, procPkg::ADD));
		addInstr(1, aluInstr(3'd3, 3'd2, 3'd3, procPkg::SUB));
		addInstr(1, aluInstr(3'd3, 3'd1, 3'd4, procPkg::XOR));
		expectWrite(1, 3'd1, 16'd5);
		expectWrite(1, 3'd1, 16'd8);
		expectWrite(1, 3'd2, 16'd7);
		expectWrite(1, 3'd3, 16'd15);
		expectWrite(1, 3'd3, 16'd8);
		expectWrite(1, 3'd4, 16'd0);
		expErr[1] = 1'b0;

		testName[2] = "storeLoad";
		addInstr(2, lbiInstr(3'd1, 8'h20));
		addInstr(2, lbiInstr(3'd2, 8'h9c));
		addInstr(2, iType(procPkg::ST, 3'd1, 3'd2, 5'd2));
		addInstr(2, iType(procPkg::LD, 3'd1, 3'd3, 5'd2));
		addInstr(2, aluInstr(3'd3, 3'd1, 3'd4, procPkg::ADD));
		expectWrite(2, 3'd1, 16'h0020);
		expectWrite(2, 3'd2, 16'hff9c);
		expectWrite(2, 3'd3, 16'hff9c);
		expectWrite(2, 3'd4, 16'hffbc);
		expErr[2] = 1'b0;

		// Writes to r7 sit in skipped slots
		testName[3] = "branches";
		addInstr(3, lbiInstr(3'd1, 8'd0));
		addInstr(3, branchInstr(procPkg::BEQZ, 3'd1, 8'd2));
		addInstr(3, lbiInstr(3'd7, 8'd1));
		addInstr(3, lbiInstr(3'd2, 8'd3));
		addInstr(3, branchInstr(procPkg::BNEZ, 3'd2, 8'd2));
		addInstr(3, lbiInstr(3'd7, 8'd2));
		addInstr(3, branchInstr(procPkg::BEQZ, 3'd2, 8'd2));
		addInstr(3, lbiInstr(3'd3, 8'd4));
		addInstr(3, branchInstr(procPkg::BNEZ, 3'd1, 8'd2));
		addInstr(3, jumpInstr(11'd2));
		addInstr(3, lbiInstr(3'd7, 8'd3));
		addInstr(3, lbiInstr(3'd4, 8'd5));
		expectWrite(3, 3'd1, 16'd0);
		expectWrite(3, 3'd2, 16'd3);
		expectWrite(3, 3'd3, 16'd4);
		expectWrite(3, 3'd4, 16'd5);
		expErr[3] = 1'b0;

		testName[4] = "misalignedLoad";
		addInstr(4, lbiInstr(3'd1, 8'h11));
		addInstr(4, iType(procPkg::LD, 3'd1, 3'd2, 5'd0));
		addInstr(4, lbiInstr(3'd3, 8'd7));
		expectWrite(4, 3'd1, 16'h0011);
		expectWrite(4, 3'd3, 16'd7);
		expErr[4] = 1'b1;

		// Opcode 11111 is unassigned
		testName[5] = "illegalOpcode";
		addInstr(5, lbiInstr(3'd1, 8'd9));
		addInstr(5, 16'hf800);
		addInstr(5, lbiInstr(3'd2, 8'd4));
		expectWrite(5, 3'd1, 16'd9);
		expErr[5] = 1'b1;
	endtask

	task automatic checkRetire(input int t, input int n);
		checks++;
		if (n >= expCount[t]) begin
			errors++;
			$display("Test %s: unexpected write of r%0d = %h", testName[t],
				retireReg, retireData);
		end else if (retireReg !== expRet[t][n].dest || retireData !== expRet[t][n].data) begin
			errors++;
			$display("Error %s: write %0d expected r%0d = %h, actual r%0d = %h", testName[t],
				n, expRet[t][n].dest, expRet[t][n].data, retireReg, retireData);
		end
	endtask

	task automatic runTest(input int t);
		int seen;
		int cycles;
		reset = 1'b1;
		for (int i = 0; i < 16; i++) begin
			@(posedge clk);
			#1;
			loadValid = 1'b1;
			loadAddr = procPkg::word'(2 * i);
			loadData = prog[t][i];
		end
		@(posedge clk);
		#1;
		loadValid = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		seen = 0;
		cycles = 0;
		while (!halted && cycles < maxCycles) begin
			@(posedge clk);
			#1;
			cycles++;
			if (retireValid) begin
				checkRetire(t, seen);
				seen++;
			end
		end
		if (!halted) begin
			errors++;
			$display("Test %s: halted did not rise within %0d cycles", testName[t], maxCycles);
		end
		// Any write after halt counts as extra
		repeat (8) begin
			@(posedge clk);
			#1;
			if (retireValid) begin
				checkRetire(t, seen);
				seen++;
			end
		end
		if (seen != expCount[t]) begin
			errors++;
			$display("Error %s: retire count expected %0d, actual %0d", testName[t],
				expCount[t], seen);
		end
		if (err !== expErr[t]) begin
			errors++;
			$display("Error %s: err expected %b, actual %b", testName[t], expErr[t], err);
		end
	endtask

	initial begin
		void'($urandom(78));
		reset = 1'b1;
		loadValid = 1'b0;
		loadAddr = '0;
		loadData = '0;
		errors = 0;
		checks = 0;
		buildTable();
		for (int t = 0; t < numTests; t++) begin
			runTest(t);
		end
		$display("Summary: %0d tests, %0d retires checked, %0d errors", numTests, checks,
			errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* testbench/proc_props.sv */
// --------------------------------------------------
// Bound checks on the processor top level
//   halted is sticky, no retire once halted
//   no retire in reset, bounded decode stall
// --------------------------------------------------
module proc_props (
	input logic clk,
	input logic reset,
	input logic retireValid,
	input logic halted,
	input logic stall
);

	timeunit 1ns;
	timeprecision 100ps;

	haltedSticky: assert property (@(posedge clk) disable iff (reset)
		halted |=> halted)
		else $error("halted fell without a reset");

	noRetireHalted: assert property (@(posedge clk) disable iff (reset)
		halted |-> !retireValid)
		else $error("register write retired while halted");

	// Writeback is registered, so one reset edge clears it
	noRetireReset: assert property (@(posedge clk)
		reset && $past(reset) |-> !retireValid)
		else $error("register write retired during reset");

	stallBounded: assert property (@(posedge clk) disable iff (reset)
		stall && $past(stall) |=> !stall)
		else $error("stall held for more than 2 cycles");

endmodule

bind proc proc_props uProps (
	.clk(clk),
	.reset(reset),
	.retireValid(retireValid),
	.halted(halted),
	.stall(stall)
);
